/* include/btac_params.svh */
`ifndef BTAC_PARAMS_SVH
`define BTAC_PARAMS_SVH

// Number of entries in the direct-mapped target table.
// It must stay a power of two, since the index is a plain slice of the pc.
`define BTAC_DEPTH 64

// Width of a pc, a target or a fall-through address.
`define BTAC_XLEN 32

`endif

/* hdl/btac_pkg.sv */
`default_nettype none

`include "btac_params.svh"

package btac_pkg;

  localparam int unsigned idx_width = $clog2(`BTAC_DEPTH); // index bits above the word offset.

  typedef logic [`BTAC_XLEN-1:0] addr_t;
  typedef logic [idx_width-1:0]  idx_t;

  // An entry that is all zero is treated as empty.
  typedef struct packed {
    addr_t tag;    // full pc of the jump.
    addr_t target; // resolved jump address.
    addr_t npc;    // fall-through pc of the jump.
  } btb_entry_t;

  typedef struct packed {
    logic       en;
    idx_t       idx;
    btb_entry_t entry;
  } btb_wr_t;

  typedef struct packed {
    addr_t pc;
    logic  clear;
  } btac_fetch_t;

  typedef struct packed {
    logic  hit;
    addr_t target;
    addr_t npc;
  } btac_pred_t;

  typedef struct packed {
    logic  jump;   // slot resolved an unconditional or taken jump.
    logic  branch; // slot holds a control transfer of any kind.
    addr_t pc;
    addr_t addr;   // resolved destination of the slot.
    addr_t npc;
  } btac_slot_t;

  typedef struct packed {
    logic  taken;
    addr_t target;
    addr_t npc;
  } btac_taken_t;

  typedef struct packed {
    logic  miss;
    addr_t addr;
  } btac_redirect_t;

  typedef enum logic [0:0] {
    TRACK_IDLE    = 1'b0,
    TRACK_PENDING = 1'b1
  } track_state_t;

  // Word-aligned pcs, so the index starts at bit 2.
  function automatic idx_t pc_to_idx(input addr_t pc);
    return pc[idx_width+1:2];
  endfunction

endpackage

`default_nettype wire

/* hdl/btb_ram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "btac_params.svh"

module btb_ram
  import btac_pkg::*;
(
  input  logic       clock,
  input  btb_wr_t    wr,
  input  idx_t       rd_idx,
  output btb_entry_t rd_entry
);

  // Contents start out empty and are never reset afterwards.
  btb_entry_t mem [0:`BTAC_DEPTH-1] = '{default: '0};

  assign rd_entry = mem[rd_idx]; // lookup sees the entry in the same cycle.

  always_ff @(posedge clock) begin
    if (wr.en) begin
      mem[wr.idx] <= wr.entry; // new entry is readable from the next cycle on.
    end
  end

endmodule

`default_nettype wire

/* hdl/btac_lookup.sv */
`timescale 1ns/100ps
`default_nettype none

module btac_lookup
  import btac_pkg::*;
(
  input  btac_fetch_t fetch,
  output idx_t        rd_idx,
  input  btb_entry_t  rd_entry,
  output btac_pred_t  pred
);

  logic entry_valid;
  logic tag_match;

  assign rd_idx = pc_to_idx(fetch.pc);

  assign entry_valid = |rd_entry;                 // an all-zero slot was never written.
  assign tag_match   = (rd_entry.tag == fetch.pc); // full pc compare rules out aliasing.

  always_comb begin
    pred = '0;
    if (!fetch.clear) begin
      pred.hit    = entry_valid && tag_match;
      pred.target = rd_entry.target; // addresses pass through, fetch only acts on hit.
      pred.npc    = rd_entry.npc;
    end
  end

endmodule

`default_nettype wire

/* hdl/btac_update.sv */
`timescale 1ns/100ps
`default_nettype none

module btac_update
  import btac_pkg::*;
(
  input  btac_fetch_t fetch,
  input  btac_slot_t  slot0,
  input  btac_slot_t  slot1,
  output btb_wr_t     wr
);

  btac_slot_t sel;
  logic       any_jump;

  assign any_jump = slot0.jump || slot1.jump;
  assign sel      = slot0.jump ? slot0 : slot1; // older slot wins when both jump.

  always_comb begin
    wr = '0;
    if (!fetch.clear && any_jump) begin
      wr.en           = 1'b1;
      wr.idx          = pc_to_idx(sel.pc);
      wr.entry.tag    = sel.pc;
      wr.entry.target = sel.addr;
      wr.entry.npc    = sel.npc;
    end
  end

endmodule

`default_nettype wire

/* hdl/btac_resolve.sv */
`timescale 1ns/100ps
`default_nettype none

module btac_resolve
  import btac_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  btac_fetch_t    fetch,
  input  btac_taken_t    taken,
  input  btac_slot_t     slot0,
  input  btac_slot_t     slot1,
  output btac_redirect_t redirect
);

  track_state_t state_q;
  track_state_t state_d;

  addr_t target_q;
  addr_t npc_q;

  logic  pending;
  addr_t exp_target;
  addr_t exp_npc;
  logic  resolved;

  // A taken report in this cycle counts as pending right away.
  assign pending    = (state_q == TRACK_PENDING) || taken.taken;
  assign exp_target = taken.taken ? taken.target : target_q;
  assign exp_npc    = taken.taken ? taken.npc : npc_q;

  always_comb begin
    redirect = '0;
    resolved = 1'b0;
    if (!fetch.clear) begin
      if (!pending) begin
        // Nothing was predicted, so any jump is a miss.
        if (slot0.jump) begin
          redirect.miss = 1'b1;
          redirect.addr = slot0.addr;
        end else if (slot1.jump) begin
          redirect.miss = 1'b1;
          redirect.addr = slot1.addr;
        end
      end else begin
        if (slot0.jump) begin
          redirect.miss = (slot0.addr != exp_target); // correct target needs no redirect.
          redirect.addr = slot0.addr;
          resolved      = 1'b1;
        end else if (slot0.branch) begin
          redirect.miss = 1'b1; // predicted taken but fell through.
          redirect.addr = exp_npc;
          resolved      = 1'b1;
        end else if (slot1.jump) begin
          redirect.miss = (slot1.addr != exp_target);
          redirect.addr = slot1.addr;
          resolved      = 1'b1;
        end else if (slot1.branch) begin
          redirect.miss = 1'b1;
          redirect.addr = exp_npc;
          resolved      = 1'b1;
        end
      end
    end
  end

  always_comb begin
    state_d = state_q;
    if (fetch.clear) begin
      state_d = TRACK_IDLE; // a flush drops whatever fetch had predicted.
    end else if (pending) begin
      state_d = resolved ? TRACK_IDLE : TRACK_PENDING;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= TRACK_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Only meaningful while the state is pending.
  always_ff @(posedge clock) begin
    if (!fetch.clear && taken.taken) begin
      target_q <= taken.target;
      npc_q    <= taken.npc;
    end
  end

endmodule

`default_nettype wire

/* hdl/btac.sv */
`timescale 1ns/100ps
`default_nettype none

module btac
  import btac_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  btac_fetch_t    fetch,
  input  btac_taken_t    taken,
  input  btac_slot_t     slot0,
  input  btac_slot_t     slot1,
  output btac_pred_t     pred,
  output btac_redirect_t redirect
);

  btb_wr_t    wr;
  idx_t       rd_idx;
  btb_entry_t rd_entry;

  btb_ram i_btb_ram (
    .clock    (clock),
    .wr       (wr),
    .rd_idx   (rd_idx),
    .rd_entry (rd_entry)
  );

  btac_lookup i_btac_lookup (
    .fetch    (fetch),
    .rd_idx   (rd_idx),
    .rd_entry (rd_entry),
    .pred     (pred)
  );

  btac_update i_btac_update (
    .fetch (fetch),
    .slot0 (slot0),
    .slot1 (slot1),
    .wr    (wr)
  );

  btac_resolve i_btac_resolve (
    .clock    (clock),
    .reset    (reset),
    .fetch    (fetch),
    .taken    (taken),
    .slot0    (slot0),
    .slot1    (slot1),
    .redirect (redirect)
  );

endmodule

`default_nettype wire

/* sim/btac_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module btac_sva
  import btac_pkg::*;
(
  input logic           clock,
  input logic           reset,
  input btac_fetch_t    fetch,
  input btac_slot_t     slot0,
  input btac_slot_t     slot1,
  input btb_wr_t        wr,
  input btac_pred_t     pred,
  input btac_redirect_t redirect
);

  clear_quiet: assert property (@(posedge clock) disable iff (!reset)
    fetch.clear |-> (pred == '0 && redirect == '0))
    else $error("pred or redirect is active while clear is high");

  miss_has_cause: assert property (@(posedge clock) disable iff (!reset)
    redirect.miss |-> (slot0.jump || slot0.branch || slot1.jump || slot1.branch))
    else $error("miss raised without a resolving slot");

  no_write_on_clear: assert property (@(posedge clock) disable iff (!reset)
    fetch.clear |-> !wr.en)
    else $error("table written while clear is high");

endmodule

bind btac btac_sva i_btac_sva (
  .clock    (clock),
  .reset    (reset),
  .fetch    (fetch),
  .slot0    (slot0),
  .slot1    (slot1),
  .wr       (wr),
  .pred     (pred),
  .redirect (redirect)
);

`default_nettype wire

/* sim/btac_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "btac_params.svh"

module btac_tb
  import btac_pkg::*;
();

  localparam int num_cycles   = 2000;
  localparam int edge_timeout = 40; // polls of 1 ns, five clock periods.
  localparam int idx_bits     = $clog2(`BTAC_DEPTH);

  logic           clock;
  logic           reset;
  btac_fetch_t    fetch;
  btac_taken_t    taken;
  btac_slot_t     slot0;
  btac_slot_t     slot1;
  btac_pred_t     pred;
  btac_redirect_t redirect;

  int          edge_count;
  logic [31:0] lfsr_state;

  btb_entry_t model_table [0:`BTAC_DEPTH-1];
  logic       model_pending;
  addr_t      model_target;
  addr_t      model_npc;

  btac i_btac (
    .clock    (clock),
    .reset    (reset),
    .fetch    (fetch),
    .taken    (taken),
    .slot0    (slot0),
    .slot1    (slot1),
    .pred     (pred),
    .redirect (redirect)
  );

  always #4 clock = ~clock;

  always @(posedge clock) begin
    edge_count <= edge_count + 1; // a poll at the edge itself still reads the old count.
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
      shifted = shifted ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1.
    end
    return shifted;
  endfunction

  task automatic random_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits[i]    = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Bit 3 lands above the index, so pcs k and k^8 alias.
  function automatic addr_t pool_pc(input logic [3:0] k);
    return 32'h0000_1000 | {23'd0, k[3], 3'd0, k[2:0], 2'b00};
  endfunction

  function automatic addr_t pool_target(input logic [1:0] k);
    return 32'h0000_4000 + {24'd0, k, 6'd0};
  endfunction

  function automatic logic [idx_bits-1:0] table_index(input addr_t pc);
    return pc[idx_bits+1:2];
  endfunction

  task automatic stop_run();
    $display("RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_value(input string what, input logic [31:0] got,
                              input logic [31:0] want);
    $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
    stop_run();
  endtask

  task automatic wait_for_edge(input int target);
    int polls;
    polls = 0;
    while (edge_count < target && polls < edge_timeout) begin
      #1;
      polls++;
    end
    assert (edge_count >= target) else begin
      $display("clock edge %0d did not arrive in time", target);
      stop_run();
    end
  endtask

  task automatic random_slot(output btac_slot_t slot);
    logic [31:0] r;
    random_bits(9, r);
    slot.jump   = &r[1:0];
    slot.branch = slot.jump || r[2];
    slot.pc     = pool_pc(r[6:3]);
    slot.addr   = pool_target(r[8:7]);
    slot.npc    = slot.pc + 32'd4;
  endtask

  task automatic drive_random_inputs();
    logic [31:0] r;
    random_bits(9, r);
    fetch.pc    = pool_pc(r[3:0]);
    fetch.clear = &r[8:4]; // about one cycle in 32.
    random_slot(slot0);
    random_slot(slot1);
    random_bits(8, r);
    taken.taken  = &r[1:0];
    taken.target = pool_target(r[3:2]);
    taken.npc    = pool_pc(r[7:4]) + 32'd4;
  endtask

  // A pending prediction is settled by the first slot that jumps or branches.
  task automatic slot_outcome(input btac_slot_t slot, input addr_t target, input addr_t fall,
                              output logic applies, output logic miss, output addr_t addr);
    applies = slot.jump || slot.branch;
    miss    = 1'b0;
    addr    = '0;
    if (slot.jump) begin
      miss = (slot.addr != target);
      addr = slot.addr;
    end else if (slot.branch) begin
      miss = 1'b1;
      addr = fall;
    end
  endtask

  task automatic check_outputs(output logic settled);
    btac_pred_t     exp_pred;
    btac_redirect_t exp_redir;
    btb_entry_t     entry;
    logic           pending;
    addr_t          target;
    addr_t          fall;
    logic           applies;
    logic           miss;
    addr_t          addr;
    exp_pred  = '0;
    exp_redir = '0;
    settled   = 1'b0;
    entry     = model_table[table_index(fetch.pc)];
    if (!fetch.clear && entry != '0 && entry.tag == fetch.pc) begin
      exp_pred.hit    = 1'b1;
      exp_pred.target = entry.target;
      exp_pred.npc    = entry.npc;
    end
    pending = model_pending || taken.taken;
    target  = taken.taken ? taken.target : model_target;
    fall    = taken.taken ? taken.npc : model_npc;
    if (!fetch.clear && !pending) begin
      if (slot0.jump || slot1.jump) begin
        exp_redir.miss = 1'b1;
        exp_redir.addr = slot0.jump ? slot0.addr : slot1.addr;
      end
    end else if (!fetch.clear) begin
      slot_outcome(slot0, target, fall, applies, miss, addr);
      if (!applies) begin
        slot_outcome(slot1, target, fall, applies, miss, addr);
      end
      if (applies) begin
        exp_redir.miss = miss;
        exp_redir.addr = addr;
        settled        = 1'b1;
      end
    end
    assert (pred.hit == exp_pred.hit) else report_value("pred.hit", pred.hit, exp_pred.hit);
    if (exp_pred.hit || fetch.clear) begin
      assert (pred.target == exp_pred.target)
        else report_value("pred.target", pred.target, exp_pred.target);
      assert (pred.npc == exp_pred.npc) else report_value("pred.npc", pred.npc, exp_pred.npc);
    end
    assert (redirect.miss == exp_redir.miss)
      else report_value("redirect.miss", redirect.miss, exp_redir.miss);
    if (exp_redir.miss || fetch.clear) begin
      assert (redirect.addr == exp_redir.addr)
        else report_value("redirect.addr", redirect.addr, exp_redir.addr);
    end
  endtask

  task automatic update_model(input logic settled);
    btac_slot_t sel;
    sel = slot0.jump ? slot0 : slot1;
    if (!fetch.clear && (slot0.jump || slot1.jump)) begin
      model_table[table_index(sel.pc)] = '{tag: sel.pc, target: sel.addr, npc: sel.npc};
    end
    if (fetch.clear) begin
      model_pending = 1'b0;
    end else if (model_pending || taken.taken) begin
      model_pending = !settled;
    end
    if (!fetch.clear && taken.taken) begin
      model_target = taken.target;
      model_npc    = taken.npc;
    end
  endtask

  initial begin
    logic settled;
    clock         = 1'b0;
    reset         = 1'b0;
    fetch         = '0;
    taken         = '0;
    slot0         = '0;
    slot1         = '0;
    edge_count    = 0;
    lfsr_state    = 32'd10;
    model_pending = 1'b0;
    model_target  = '0;
    model_npc     = '0;
    for (int i = 0; i < `BTAC_DEPTH; i++) begin
      model_table[i] = '0;
    end
    wait_for_edge(2);
    reset = 1'b1;
    for (int cycle = 0; cycle < num_cycles; cycle++) begin
      drive_random_inputs();
      if (cycle == 0) begin
        fetch = '0; // pc zero equals the tag of an empty entry, only the valid test misses it.
      end
      #2;
      check_outputs(settled);
      update_model(settled);
      wait_for_edge(edge_count + 1);
    end
    fetch = '0;
    taken = '0;
    slot0 = '0;
    slot1 = '0;
    wait_for_edge(edge_count + 2);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
hdl/btac_pkg.sv
hdl/btb_ram.sv
hdl/btac_lookup.sv
hdl/btac_update.sv
hdl/btac_resolve.sv
hdl/btac.sv
sim/btac_sva.sv
sim/btac_tb.sv

/* Bender.yml */
package:
  name: btac

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/btac_pkg.sv
      - hdl/btb_ram.sv
      - hdl/btac_lookup.sv
      - hdl/btac_update.sv
      - hdl/btac_resolve.sv
      - hdl/btac.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/btac_sva.sv
      - sim/btac_tb.sv
